// ==== core_pkg.sv ====
// ======================================================================
// shared widths and encodings for the RV32I subset pipeline
// only OP, OP-IMM and LUI opcodes are known, anything else is illegal
// ======================================================================
package core_pkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // x0..x31
    localparam int INST_W     = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // reg-reg
        OPC_OP_IMM = 7'b0010011, // reg-imm
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // alu operations carried down the pipe
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

// ==== core_decode.sv ====
// ======================================================================
// combinational decoder and input handshake, ready is simply ~stall
// illegal words become writeless x0+0 adds, rd of x0 never writes
// ======================================================================
module core_decode (
    input  logic                            inst_valid_i,
    output logic                            inst_ready_o,
    input  logic [core_pkg::INST_W-1:0]     inst_i,
    input  logic [core_pkg::XLEN-1:0]       inst_addr_i,
    input  logic                            stall_i,
    output logic                            dec_valid_o,
    output logic [core_pkg::XLEN-1:0]       dec_addr_o,
    output logic                            dec_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] dec_rd_o,
    output logic [core_pkg::REG_ADDR_W-1:0] dec_rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] dec_rs2_o,
    output core_pkg::alu_op_e               dec_op_o,
    output logic                            dec_use_imm_o,
    output logic [core_pkg::XLEN-1:0]       dec_imm_o
);

    core_pkg::opcode_e opc;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              f7_ok;   // funct7 is zero, or 0100000 on SUB/SRA slots
    logic              legal;
    logic              alt;     // selects SUB over ADD, SRA over SRL

    assign opc    = core_pkg::opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign f7_ok  = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    assign inst_ready_o = ~stall_i;                // holds off while result is blocked
    assign dec_valid_o  = inst_valid_i & ~stall_i; // accepted this edge
    assign dec_addr_o   = inst_addr_i;
    assign dec_rd_o     = inst_i[11:7];
    assign dec_rs2_o    = inst_i[24:20];
    assign dec_we_o     = legal & (dec_rd_o != '0); // the only x0 write check

    always_comb begin
        legal         = 1'b0;
        alt           = 1'b0;
        dec_rs1_o     = inst_i[19:15];
        dec_use_imm_o = 1'b1;
        dec_imm_o     = {{20{inst_i[31]}}, inst_i[31:20]}; // I-immediate
        case (opc)
            core_pkg::OPC_OP: begin
                legal         = f7_ok;
                alt           = funct7[5];
                dec_use_imm_o = 1'b0;
            end
            core_pkg::OPC_OP_IMM: begin
                legal = (funct3[1:0] != 2'b01) || f7_ok; // shifts check funct7
                alt   = funct7[5] & (funct3 == 3'b101);  // no SUBI
            end
            core_pkg::OPC_LUI: begin
                legal     = 1'b1;
                dec_rs1_o = '0;                        // x0 + U-immediate
                dec_imm_o = {inst_i[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase

        case (funct3)
            3'b000:  dec_op_o = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  dec_op_o = core_pkg::ALU_SLL;
            3'b010:  dec_op_o = core_pkg::ALU_SLT;
            3'b011:  dec_op_o = core_pkg::ALU_SLTU;
            3'b100:  dec_op_o = core_pkg::ALU_XOR;
            3'b101:  dec_op_o = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  dec_op_o = core_pkg::ALU_OR;
            default: dec_op_o = core_pkg::ALU_AND;
        endcase
        if (opc == core_pkg::OPC_LUI) dec_op_o = core_pkg::ALU_ADD;

        if (!legal) begin // illegal word yields x0 + 0
            dec_rs1_o     = '0;
            dec_imm_o     = '0;
            dec_use_imm_o = 1'b1;
            dec_op_o      = core_pkg::ALU_ADD;
        end
    end

endmodule

// ==== idu_id_pipe.sv ====
// ======================================================================
// decode to execute register, carries register addresses not data
// holds on stall, loads a writeless bubble when no instruction comes
// ======================================================================
module idu_id_pipe (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  logic                            dec_valid_i,
    input  logic [core_pkg::XLEN-1:0]       dec_addr_i,
    input  logic                            dec_we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rd_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs2_i,
    input  core_pkg::alu_op_e               dec_op_i,
    input  logic                            dec_use_imm_i,
    input  logic [core_pkg::XLEN-1:0]       dec_imm_i,
    output logic                            ex_valid_o,
    output logic [core_pkg::XLEN-1:0]       ex_addr_o,
    output logic                            ex_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rd_o,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rs2_o,
    output core_pkg::alu_op_e               ex_op_o,
    output logic                            ex_use_imm_o,
    output logic [core_pkg::XLEN-1:0]       ex_imm_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_addr_o    <= '0;
            ex_we_o      <= 1'b0;
            ex_rd_o      <= '0;
            ex_rs1_o     <= '0;
            ex_rs2_o     <= '0;
            ex_op_o      <= core_pkg::ALU_ADD;
            ex_use_imm_o <= 1'b0;
            ex_imm_o     <= '0;
        end else if (!stall_i) begin                 // stall keeps every field
            ex_valid_o   <= dec_valid_i;
            ex_we_o      <= dec_valid_i & dec_we_i;   // bubble never writes
            ex_addr_o    <= dec_addr_i;
            ex_rd_o      <= dec_rd_i;
            ex_rs1_o     <= dec_rs1_i;
            ex_rs2_o     <= dec_rs2_i;
            ex_op_o      <= dec_op_i;
            ex_use_imm_o <= dec_use_imm_i;
            ex_imm_o     <= dec_imm_i;
        end
    end

endmodule

// ==== core_regfile.sv ====
// ======================================================================
// x1..x31 with two async read ports, x0 is hardwired to zero
// write and read of the same register in one cycle returns old data
// ======================================================================
module core_regfile (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);

    logic [core_pkg::XLEN-1:0] regs [1:31]; // no storage for x0

    always_ff @(posedge clk) begin
        for (int i = 1; i < 32; i++) begin
            if (!rst_n_i)
                regs[i] <= '0;
            else if (we_i && waddr_i == i[core_pkg::REG_ADDR_W-1:0])
                regs[i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== core_execute.sv ====
// ======================================================================
// operand read, bypass from the held result, and the ALU
// fully combinational, shift amount is the low 5 bits of operand b
// ======================================================================
module core_execute (
    input  logic                            ex_valid_i,
    input  logic [core_pkg::XLEN-1:0]       ex_addr_i,
    input  logic                            ex_we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rs2_i,
    input  core_pkg::alu_op_e               ex_op_i,
    input  logic                            ex_use_imm_i,
    input  logic [core_pkg::XLEN-1:0]       ex_imm_i,
    input  logic [core_pkg::XLEN-1:0]       rf_rdata1_i,
    input  logic [core_pkg::XLEN-1:0]       rf_rdata2_i,
    input  logic                            fwd_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] fwd_rd_i,
    input  logic [core_pkg::XLEN-1:0]       fwd_data_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr2_o,
    output logic                            exr_valid_o,
    output logic [core_pkg::XLEN-1:0]       exr_addr_o,
    output logic                            exr_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] exr_rd_o,
    output logic [core_pkg::XLEN-1:0]       exr_data_o
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] rs2_val;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [4:0]                shamt;

    assign rf_raddr1_o = ex_rs1_i;
    assign rf_raddr2_o = ex_rs2_i;

    // fwd_valid implies a nonzero rd, so x0 never matches
    assign op_a    = (fwd_valid_i && fwd_rd_i == ex_rs1_i) ? fwd_data_i : rf_rdata1_i;
    assign rs2_val = (fwd_valid_i && fwd_rd_i == ex_rs2_i) ? fwd_data_i : rf_rdata2_i;
    assign op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (ex_op_i)
            core_pkg::ALU_ADD:  exr_data_o = op_a + op_b;
            core_pkg::ALU_SUB:  exr_data_o = op_a - op_b;
            core_pkg::ALU_SLL:  exr_data_o = op_a << shamt;
            core_pkg::ALU_SLT:  exr_data_o = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: exr_data_o = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:  exr_data_o = op_a ^ op_b;
            core_pkg::ALU_SRL:  exr_data_o = op_a >> shamt;
            core_pkg::ALU_SRA:  exr_data_o = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:   exr_data_o = op_a | op_b;
            core_pkg::ALU_AND:  exr_data_o = op_a & op_b;
            default:            exr_data_o = '0;
        endcase
    end

    assign exr_valid_o = ex_valid_i;
    assign exr_addr_o  = ex_addr_i;
    assign exr_we_o    = ex_we_i;   // already cleared for bubbles
    assign exr_rd_o    = ex_rd_i;

endmodule

// ==== core_result.sv ====
// ======================================================================
// one-entry result slot with valid/ready output, writes back on take
// stall is raised only while a held result is not being taken
// ======================================================================
module core_result (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            exr_valid_i,
    input  logic [core_pkg::XLEN-1:0]       exr_addr_i,
    input  logic                            exr_we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] exr_rd_i,
    input  logic [core_pkg::XLEN-1:0]       exr_data_i,
    input  logic                            res_ready_i,
    output logic                            res_valid_o,
    output logic [core_pkg::XLEN-1:0]       res_addr_o,
    output logic                            res_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic [core_pkg::XLEN-1:0]       res_data_o,
    output logic                            stall_o,
    output logic                            rf_we_o,
    output logic                            fwd_valid_o
);

    assign stall_o     = res_valid_o & ~res_ready_i;           // blocked slot
    assign rf_we_o     = res_valid_o & res_ready_i & res_we_o; // write on take
    assign fwd_valid_o = res_valid_o & res_we_o;               // not yet in regfile

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
            res_we_o    <= 1'b0;
        end else if (!stall_o) begin // empty or taken, next one moves in
            res_valid_o <= exr_valid_i;
            res_we_o    <= exr_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            res_addr_o <= exr_addr_i;
            res_rd_o   <= exr_rd_i;
            res_data_o <= exr_data_i;
        end
    end

endmodule

// ==== core_top.sv ====
// ======================================================================
// RV32I subset core: decode, pipe register, execute, result, regfile
// two edges from accept to result valid, back-pressure via res_ready_i
// ======================================================================
module core_top (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            inst_valid_i,
    output logic                            inst_ready_o,
    input  logic [core_pkg::INST_W-1:0]     inst_i,
    input  logic [core_pkg::XLEN-1:0]       inst_addr_i,
    output logic                            res_valid_o,
    input  logic                            res_ready_i,
    output logic [core_pkg::XLEN-1:0]       res_addr_o,
    output logic                            res_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] res_rd_o,
    output logic [core_pkg::XLEN-1:0]       res_data_o
);

    logic                            stall;
    logic                            dec_valid, dec_we, dec_use_imm;
    logic [core_pkg::XLEN-1:0]       dec_addr, dec_imm;
    logic [core_pkg::REG_ADDR_W-1:0] dec_rd, dec_rs1, dec_rs2;
    core_pkg::alu_op_e               dec_op;
    logic                            ex_valid, ex_we, ex_use_imm;
    logic [core_pkg::XLEN-1:0]       ex_addr, ex_imm;
    logic [core_pkg::REG_ADDR_W-1:0] ex_rd, ex_rs1, ex_rs2;
    core_pkg::alu_op_e               ex_op;
    logic [core_pkg::REG_ADDR_W-1:0] rf_raddr1, rf_raddr2;
    logic [core_pkg::XLEN-1:0]       rf_rdata1, rf_rdata2;
    logic                            exr_valid, exr_we;
    logic [core_pkg::XLEN-1:0]       exr_addr, exr_data;
    logic [core_pkg::REG_ADDR_W-1:0] exr_rd;
    logic                            rf_we, fwd_valid;

    core_decode u_decode (
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .stall_i      (stall),
        .dec_valid_o  (dec_valid),
        .dec_addr_o   (dec_addr),
        .dec_we_o     (dec_we),
        .dec_rd_o     (dec_rd),
        .dec_rs1_o    (dec_rs1),
        .dec_rs2_o    (dec_rs2),
        .dec_op_o     (dec_op),
        .dec_use_imm_o(dec_use_imm),
        .dec_imm_o    (dec_imm)
    );

    idu_id_pipe u_id_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall),
        .dec_valid_i  (dec_valid),
        .dec_addr_i   (dec_addr),
        .dec_we_i     (dec_we),
        .dec_rd_i     (dec_rd),
        .dec_rs1_i    (dec_rs1),
        .dec_rs2_i    (dec_rs2),
        .dec_op_i     (dec_op),
        .dec_use_imm_i(dec_use_imm),
        .dec_imm_i    (dec_imm),
        .ex_valid_o   (ex_valid),
        .ex_addr_o    (ex_addr),
        .ex_we_o      (ex_we),
        .ex_rd_o      (ex_rd),
        .ex_rs1_o     (ex_rs1),
        .ex_rs2_o     (ex_rs2),
        .ex_op_o      (ex_op),
        .ex_use_imm_o (ex_use_imm),
        .ex_imm_o     (ex_imm)
    );

    core_execute u_execute (
        .ex_valid_i  (ex_valid),
        .ex_addr_i   (ex_addr),
        .ex_we_i     (ex_we),
        .ex_rd_i     (ex_rd),
        .ex_rs1_i    (ex_rs1),
        .ex_rs2_i    (ex_rs2),
        .ex_op_i     (ex_op),
        .ex_use_imm_i(ex_use_imm),
        .ex_imm_i    (ex_imm),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .fwd_valid_i (fwd_valid),
        .fwd_rd_i    (res_rd_o),   // bypass straight from the held result
        .fwd_data_i  (res_data_o),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .exr_valid_o (exr_valid),
        .exr_addr_o  (exr_addr),
        .exr_we_o    (exr_we),
        .exr_rd_o    (exr_rd),
        .exr_data_o  (exr_data)
    );

    core_regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2),
        .we_i    (rf_we),
        .waddr_i (res_rd_o),
        .wdata_i (res_data_o),
        .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2)
    );

    core_result u_result (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .exr_valid_i(exr_valid),
        .exr_addr_i (exr_addr),
        .exr_we_i   (exr_we),
        .exr_rd_i   (exr_rd),
        .exr_data_i (exr_data),
        .res_ready_i(res_ready_i),
        .res_valid_o(res_valid_o),
        .res_addr_o (res_addr_o),
        .res_we_o   (res_we_o),
        .res_rd_o   (res_rd_o),
        .res_data_o (res_data_o),
        .stall_o    (stall),
        .rf_we_o    (rf_we),
        .fwd_valid_o(fwd_valid)
    );

endmodule

// ==== tb_core.sv ====
// ======================================================================
// random in-order test of core_top against a reference model
// stimulus uses x0..x7 only, so most instructions depend on recent ones
// ======================================================================
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int N_INST       = 400;

    logic                            clk = 1'b0;
    logic                            rst_n_i;
    logic                            inst_valid_i;
    logic                            inst_ready_o;
    logic [core_pkg::INST_W-1:0]     inst_i;
    logic [core_pkg::XLEN-1:0]       inst_addr_i;
    logic                            res_valid_o;
    logic                            res_ready_i;
    logic [core_pkg::XLEN-1:0]       res_addr_o;
    logic                            res_we_o;
    logic [core_pkg::REG_ADDR_W-1:0] res_rd_o;
    logic [core_pkg::XLEN-1:0]       res_data_o;

    integer                    seed;
    int                        errors;
    int                        accepted;
    int                        taken;
    logic [core_pkg::XLEN-1:0] model_regs [0:31]; // in-order register state
    logic [69:0]               exp_q [$];         // {addr, we, rd, data}
    logic                      held;              // result blocked last edge
    logic [69:0]               held_val;

    core_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // RV32I semantics for the supported subset, returns {we, rd, data}
    function automatic logic [37:0] ref_model(input logic [31:0] w);
        logic [6:0]                opc;
        logic [2:0]                f3;
        logic [6:0]                f7;
        logic [4:0]                rd;
        logic                      legal;
        logic [core_pkg::XLEN-1:0] a;
        logic [core_pkg::XLEN-1:0] b;
        logic [core_pkg::XLEN-1:0] d;
        core_pkg::alu_op_e         op;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = model_regs[w[19:15]];
        b   = (opc == core_pkg::OPC_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        if (opc == core_pkg::OPC_OP)
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (opc == core_pkg::OPC_OP_IMM)
            legal = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
        else
            legal = (opc == core_pkg::OPC_LUI);
        case (f3)
            3'd0:    op = (opc == core_pkg::OPC_OP && f7[5]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'd1:    op = core_pkg::ALU_SLL;
            3'd2:    op = core_pkg::ALU_SLT;
            3'd3:    op = core_pkg::ALU_SLTU;
            3'd4:    op = core_pkg::ALU_XOR;
            3'd5:    op = f7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'd6:    op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        case (op)
            core_pkg::ALU_ADD:  d = a + b;
            core_pkg::ALU_SUB:  d = a - b;
            core_pkg::ALU_SLL:  d = a << b[4:0];
            core_pkg::ALU_SLT:  d = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::ALU_SLTU: d = (a < b) ? 32'd1 : 32'd0;
            core_pkg::ALU_XOR:  d = a ^ b;
            core_pkg::ALU_SRL:  d = a >> b[4:0];
            core_pkg::ALU_SRA:  d = $unsigned($signed(a) >>> b[4:0]);
            core_pkg::ALU_OR:   d = a | b;
            default:            d = a & b;
        endcase
        if (opc == core_pkg::OPC_LUI) d = {w[31:12], 12'h000};
        if (!legal) d = '0;                                 // illegal is a zero non-write
        return {legal && rd != 5'd0, rd, d};
    endfunction

    // random word from the subset, about one in eight illegal
    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = $random(seed);
        w   = $random(seed);                                // immediates and junk
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        case (r[15:13])
            3'd0, 3'd1, 3'd2: begin                         // R-type
                w = {((f3 == 3'd0 || f3 == 3'd5) && r[16]) ? 7'h20 : 7'h00,
                     rs2, rs1, f3, rd, core_pkg::OPC_OP};
            end
            3'd3, 3'd4, 3'd5: begin                         // I-type
                if (f3 == 3'd1) w[31:25] = 7'h00;
                if (f3 == 3'd5) w[31:25] = r[16] ? 7'h20 : 7'h00;
                w = {w[31:20], rs1, f3, rd, core_pkg::OPC_OP_IMM};
            end
            3'd6: w = {w[31:12], rd, core_pkg::OPC_LUI};
            default: begin
                if (r[16])
                    w = {7'h01, rs2, rs1, f3, rd, core_pkg::OPC_OP}; // M-extension slot
                else if (w[6:0] == core_pkg::OPC_OP || w[6:0] == core_pkg::OPC_OP_IMM ||
                         w[6:0] == core_pkg::OPC_LUI)
                    w[6:0] = 7'b1100011;                    // branch opcode
            end
        endcase
        return w;
    endfunction

    // accept, hold and take checks, all sampled on the edge
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (accepted == 0)
                assert (!res_valid_o && inst_ready_o) else begin
                    errors++;
                    $display("error: res_valid_o %h inst_ready_o %h before first instruction",
                             res_valid_o, inst_ready_o);
                end
            if (held) begin                                 // blocked result must not move
                check_value("res_valid_o while stalled", {31'b0, res_valid_o}, 32'd1);
                check_value("res_addr_o while stalled", res_addr_o, held_val[69:38]);
                check_value("res_we_o while stalled", {31'b0, res_we_o},
                            {31'b0, held_val[37]});
                check_value("res_rd_o while stalled", {27'b0, res_rd_o},
                            {27'b0, held_val[36:32]});
                check_value("res_data_o while stalled", res_data_o, held_val[31:0]);
            end
            if (res_valid_o && !res_ready_i)
                check_value("inst_ready_o", {31'b0, inst_ready_o}, 32'd0);
            held     = res_valid_o && !res_ready_i;
            held_val = {res_addr_o, res_we_o, res_rd_o, res_data_o};
            if (inst_valid_i && inst_ready_o) begin         // model runs in program order
                exp_q.push_back({inst_addr_i, ref_model(inst_i)});
                if (exp_q[$][37]) model_regs[exp_q[$][36:32]] = exp_q[$][31:0];
                accepted++;
            end
            if (res_valid_o && res_ready_i) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("a result was taken with no instruction outstanding");
                end
                if (exp_q.size() > 0) begin
                    check_value("res_addr_o", res_addr_o, exp_q[0][69:38]);
                    check_value("res_we_o", {31'b0, res_we_o}, {31'b0, exp_q[0][37]});
                    check_value("res_rd_o", {27'b0, res_rd_o}, {27'b0, exp_q[0][36:32]});
                    check_value("res_data_o", res_data_o, exp_q[0][31:0]);
                    void'(exp_q.pop_front());
                end
                taken++;
            end
        end
    end

    initial begin : drive
        logic fire;
        seed         = 32'hef63;
        errors       = 0;
        accepted     = 0;
        taken        = 0;
        held         = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        res_ready_i  = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        while (taken < N_INST) begin
            @(posedge clk);
            fire = inst_valid_i && inst_ready_o;
            #1;
            if (fire) inst_valid_i = 1'b0;                  // word stays until taken
            if (!inst_valid_i && accepted < N_INST && ({$random(seed)} % 10) >= 3) begin
                inst_i       = gen_inst();
                inst_addr_i  = accepted * 4;
                inst_valid_i = 1'b1;
            end
            res_ready_i = ({$random(seed)} % 10) >= 3;      // ~30% back-pressure
        end
        repeat (4) @(posedge clk);
        assert (accepted == taken && exp_q.size() == 0) else begin
            errors++;
            $display("accepted and taken counts differ or results are missing");
        end
        $display("errors %0d, accepted %0d, taken %0d", errors, accepted, taken);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((N_INST * 8 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout with %0d of %0d results taken, %0d errors", taken, N_INST, errors);
        $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
core_pkg.sv
core_decode.sv
idu_id_pipe.sv
core_regfile.sv
core_execute.sv
core_result.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
